//--- run.sh
#!/bin/sh
# build and run the vector multiply testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_vmul -f src.f
./obj_dir/Vtb_vmul | tee sim.log

# pass only when the testbench reported a clean run
grep -q "^No errors$" sim.log
echo "simulation passed"

//--- src.f
verilog/vmul_cfg_pkg.sv
verilog/vmul_op_pkg.sv
verilog/vmul_ifs.sv
verilog/vmul_sequencer.sv
verilog/vmul_chunk_fifo.sv
verilog/vmul_lane.sv
verilog/vmul_result_collector.sv
verilog/vmul_top.sv
tb/vmul_properties.sv
tb/tb_vmul.sv

//--- tb/tb_vmul.sv
`timescale 1ns/1ns
/* vector multiply unit testbench
   random operations checked against an element-wise reference model */
module tb_vmul;
    import vmul_cfg_pkg::*;
    import vmul_op_pkg::*;

    localparam int unsigned VREG_W          = DEF_VREG_W;
    localparam int          CLK_PERIOD      = 8;
    localparam int          DRIVE_DELAY     = 1;
    localparam int          RST_CYCLES      = 3;
    localparam int          NUM_OPS         = 200;
    localparam int          WATCHDOG_CYCLES = NUM_OPS * 40;

    logic              clk_i;
    logic              async_rst_ni;
    logic              op_rdy_i;
    logic              op_ack_o;
    logic [VREG_W-1:0] vs1_i;
    logic [VREG_W-1:0] vs2_i;
    sew_e              sew_i;
    mul_op_e           op_i;
    logic              res_valid_o;
    logic [VREG_W-1:0] res_vd_o;
    logic              res_ready_i;

    int                seed = 56;
    logic [VREG_W-1:0] expected_q[$];

    vmul_top u_dut (
        .clk_i        ( clk_i        ),
        .async_rst_ni ( async_rst_ni ),
        .op_rdy_i     ( op_rdy_i     ),
        .op_ack_o     ( op_ack_o     ),
        .vs1_i        ( vs1_i        ),
        .vs2_i        ( vs2_i        ),
        .sew_i        ( sew_i        ),
        .op_i         ( op_i         ),
        .res_valid_o  ( res_valid_o  ),
        .res_vd_o     ( res_vd_o     ),
        .res_ready_i  ( res_ready_i  )
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    ////////////////////////////////////////
    // error reporting

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_equal(input logic [VREG_W-1:0] actual,
                               input logic [VREG_W-1:0] expected,
                               input string             what);
        if (actual !== expected) begin
            $display("FAIL %0t: %s, got %h, expected %h", $time, what, actual, expected);
            $display("Errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    ////////////////////////////////////////
    // reference model

    // vs2 is signed for vmulh and vmulhsu, vs1 only for vmulh
    function automatic logic [VREG_W-1:0] model_vd(input logic [VREG_W-1:0] vs1,
                                                   input logic [VREG_W-1:0] vs2,
                                                   input sew_e              sew,
                                                   input mul_op_e           op);
        int                w;
        logic [63:0]       mask;
        logic [63:0]       a;
        logic [63:0]       b;
        logic [63:0]       p;
        logic [63:0]       r;
        logic [VREG_W-1:0] vd;
        case (sew)
            SEW_8:   w = 8;
            SEW_16:  w = 16;
            default: w = 32;
        endcase
        mask = (64'd1 << w) - 1;
        vd   = '0;
        for (int i = 0; i < VREG_W / w; i++) begin
            a = 64'(vs2 >> (i * w)) & mask;
            b = 64'(vs1 >> (i * w)) & mask;
            if ((op == MUL_VMULH || op == MUL_VMULHSU) && a[w-1]) begin
                a = a | ~mask;
            end
            if (op == MUL_VMULH && b[w-1]) begin
                b = b | ~mask;
            end
            // the exact product fits in 64 bits, so wrapping keeps it intact
            p  = a * b;
            r  = (op == MUL_VMUL) ? (p & mask) : ((p >> w) & mask);
            vd = vd | (VREG_W'(r) << (i * w));
        end
        return vd;
    endfunction

    // mostly random words, with sign boundary patterns mixed in
    function automatic logic [VREG_W-1:0] random_vector();
        logic [VREG_W-1:0] v;
        logic [31:0]       word;
        v = '0;
        for (int i = 0; i < VREG_W / 32; i++) begin
            case ($random(seed) & 7)
                0:       word = 32'h8080_8080;
                1:       word = 32'hFFFF_FFFF;
                2:       word = 32'h8000_7FFF;
                3:       word = 32'h7F01_FF80;
                default: word = $random(seed);
            endcase
            v[32*i +: 32] = word;
        end
        return v;
    endfunction

    ////////////////////////////////////////
    // requester and consumer

    task automatic run_requests();
        logic [VREG_W-1:0] vs1;
        logic [VREG_W-1:0] vs2;
        sew_e              sew;
        mul_op_e           op;
        int unsigned       gap;
        for (int n = 0; n < NUM_OPS; n++) begin
            gap = $unsigned($random(seed)) % 8;
            if (gap > 3) begin
                gap = 0;
            end
            if (gap != 0) begin
                repeat (gap) @(posedge clk_i);
                #(DRIVE_DELAY);
            end
            vs1 = random_vector();
            vs2 = random_vector();
            sew = sew_e'(2'($unsigned($random(seed)) % 3));
            op  = mul_op_e'(2'($random(seed)));
            op_rdy_i = 1'b1;
            vs1_i    = vs1;
            vs2_i    = vs2;
            sew_i    = sew;
            op_i     = op;
            expected_q.push_back(model_vd(vs1, vs2, sew, op));
            // hold the request until the unit takes it
            do @(posedge clk_i); while (!op_ack_o);
            #(DRIVE_DELAY);
            op_rdy_i = 1'b0;
        end
    endtask

    task automatic collect_results();
        int                n_checked;
        logic              held;
        logic [VREG_W-1:0] held_vd;
        logic [VREG_W-1:0] expected;
        n_checked = 0;
        held      = 1'b0;
        held_vd   = '0;
        while (n_checked < NUM_OPS) begin
            @(posedge clk_i);
            if (held) begin
                check_equal(VREG_W'(res_valid_o), VREG_W'(1), "res_valid_o dropped while held");
                check_equal(res_vd_o, held_vd, "res_vd_o changed while held");
            end
            if (res_valid_o && res_ready_i) begin
                if (expected_q.size() == 0) begin
                    abort_run("a result came out with no request outstanding");
                end
                expected = expected_q.pop_front();
                check_equal(res_vd_o, expected, $sformatf("result %0d", n_checked));
                n_checked++;
            end
            held    = res_valid_o && !res_ready_i;
            held_vd = res_vd_o;
            #(DRIVE_DELAY);
            res_ready_i = ($random(seed) & 3) != 0;
        end
    endtask

    ////////////////////////////////////////
    // main sequence

    initial begin
        async_rst_ni = 1'b0;
        op_rdy_i     = 1'b0;
        vs1_i        = '0;
        vs2_i        = '0;
        sew_i        = SEW_8;
        op_i         = MUL_VMUL;
        res_ready_i  = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_i);
        #(DRIVE_DELAY);
        async_rst_ni = 1'b1;

        // nothing requested yet, so both outputs stay low
        repeat (3) begin
            @(posedge clk_i);
            check_equal(VREG_W'(op_ack_o), '0, "op_ack_o without a request");
            check_equal(VREG_W'(res_valid_o), '0, "res_valid_o without a request");
        end
        #(DRIVE_DELAY);

        fork
            run_requests();
            collect_results();
        join

        // all results are in, no further one may appear
        res_ready_i = 1'b1;
        repeat (20) begin
            @(posedge clk_i);
            if (res_valid_o) begin
                abort_run("an extra result came out after all requests were answered");
            end
        end
        if (expected_q.size() != 0) begin
            abort_run("expected results are left over at the end of the run");
        end else begin
            $display("%0d operations checked", NUM_OPS);
            $display("No errors");
            $finish;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        abort_run($sformatf("timeout, the run did not finish within %0d cycles",
                            WATCHDOG_CYCLES));
    end

endmodule

//--- tb/vmul_properties.sv
`timescale 1ns/1ns
/* handshake assertions on the vector multiply top level */
module vmul_properties #(
    parameter int unsigned VREG_W = vmul_cfg_pkg::DEF_VREG_W
) (
    input logic              clk_i,
    input logic              async_rst_ni,
    input logic              op_rdy_i,
    input logic              op_ack_o,
    input logic              res_valid_o,
    input logic [VREG_W-1:0] res_vd_o,
    input logic              res_ready_i
);

    // acknowledge answers a pending request with a single-cycle pulse
    ack_needs_request: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        op_ack_o |-> op_rdy_i ##1 !op_ack_o)
        else $error("op_ack_o high without op_rdy_i or longer than one cycle");

    // a held result keeps its value until taken
    result_held_stable: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        (res_valid_o && !res_ready_i) |=> (res_valid_o && $stable(res_vd_o)))
        else $error("held result dropped or changed before res_ready_i");

    quiet_after_reset: assert property (@(posedge clk_i)
        $rose(async_rst_ni) |-> (!res_valid_o && !op_ack_o))
        else $error("res_valid_o or op_ack_o high right after reset");

endmodule

bind vmul_top vmul_properties #(
    .VREG_W       ( VREG_W       )
) u_props (
    .clk_i        ( clk_i        ),
    .async_rst_ni ( async_rst_ni ),
    .op_rdy_i     ( op_rdy_i     ),
    .op_ack_o     ( op_ack_o     ),
    .res_valid_o  ( res_valid_o  ),
    .res_vd_o     ( res_vd_o     ),
    .res_ready_i  ( res_ready_i  )
);

//--- verilog/vmul_cfg_pkg.sv
/* vector multiply unit datapath configuration
   chunk width, word types and default sizes shared by all blocks */
package vmul_cfg_pkg;

    ////////////////////////////////////////
    // chunk and product widths

    // width of one operand chunk, handled per cycle
    localparam int unsigned MUL_OP_W = 32;

    // one operand or product chunk
    typedef logic [MUL_OP_W-1:0] op_word_t;

    // element operand after sign or zero extension, one bit wider than a chunk
    typedef logic [MUL_OP_W:0] elem_ext_t;

    // full double-width product of two chunk-sized elements
    typedef logic [2*MUL_OP_W-1:0] prod_dword_t;

    ////////////////////////////////////////
    // default sizes

    // vector register width in bits
    localparam int unsigned DEF_VREG_W = 128;

    // entries in the operand chunk FIFO, a power of two
    localparam int unsigned DEF_FIFO_DEPTH = 4;

endpackage

//--- verilog/vmul_chunk_fifo.sv
`timescale 1ns/1ns
/* operand chunk FIFO between sequencer and multiply lane */
module vmul_chunk_fifo #(
    parameter int unsigned FIFO_DEPTH = vmul_cfg_pkg::DEF_FIFO_DEPTH
) (
    input  logic      clk_i,
    input  logic      async_rst_ni,
    vmul_chunk_if.dst wr,
    vmul_chunk_if.src rd
);
    import vmul_cfg_pkg::*;
    import vmul_op_pkg::*;

    localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);
    localparam int unsigned CNT_W = PTR_W + 1;

    if (FIFO_DEPTH < 2 || (FIFO_DEPTH & (FIFO_DEPTH - 1)) != 0) begin : g_bad_depth
        $fatal(1, "FIFO_DEPTH must be a power of two and at least 2, got %0d", FIFO_DEPTH);
    end

    op_word_t         vs1_mem  [FIFO_DEPTH];
    op_word_t         vs2_mem  [FIFO_DEPTH];
    sew_e             sew_mem  [FIFO_DEPTH];
    mul_op_e          op_mem   [FIFO_DEPTH];
    logic             last_mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_wr;
    logic             do_rd;

    assign wr.ready = count_q != CNT_W'(FIFO_DEPTH);
    assign rd.valid = count_q != '0;
    assign do_wr    = wr.valid & wr.ready;
    assign do_rd    = rd.valid & rd.ready;

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_rd) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_wr) begin
            vs1_mem[wr_ptr_q]  <= wr.vs1_word;
            vs2_mem[wr_ptr_q]  <= wr.vs2_word;
            sew_mem[wr_ptr_q]  <= wr.sew;
            op_mem[wr_ptr_q]   <= wr.op;
            last_mem[wr_ptr_q] <= wr.last;
        end
    end

    assign rd.vs1_word = vs1_mem[rd_ptr_q];
    assign rd.vs2_word = vs2_mem[rd_ptr_q];
    assign rd.sew      = sew_mem[rd_ptr_q];
    assign rd.op       = op_mem[rd_ptr_q];
    assign rd.last     = last_mem[rd_ptr_q];

endmodule

//--- verilog/vmul_ifs.sv
`timescale 1ns/1ns
/* operand chunk and product chunk streams, valid/ready handshake */
interface vmul_chunk_if;
    import vmul_cfg_pkg::*;
    import vmul_op_pkg::*;

    logic     valid;
    logic     ready;
    op_word_t vs1_word;
    op_word_t vs2_word;
    sew_e     sew;
    mul_op_e  op;
    // final chunk of a vector
    logic     last;

    modport src (output valid, vs1_word, vs2_word, sew, op, last, input ready);
    modport dst (input valid, vs1_word, vs2_word, sew, op, last, output ready);
endinterface

interface vmul_prod_if;
    import vmul_cfg_pkg::*;

    logic     valid;
    logic     ready;
    op_word_t prod_word;
    logic     last;

    modport src (output valid, prod_word, last, input ready);
    modport dst (input valid, prod_word, last, output ready);
endinterface

//--- verilog/vmul_lane.sv
`timescale 1ns/1ns
/* multiply lane, element-wise products of one chunk per cycle
   keeps the low or high half of each product in a single output register */
module vmul_lane (
    input  logic      clk_i,
    input  logic      async_rst_ni,
    vmul_chunk_if.dst chunk_i,
    vmul_prod_if.src  prod_o
);
    import vmul_cfg_pkg::*;
    import vmul_op_pkg::*;

    // signed product of two operands already extended by one bit
    function automatic prod_dword_t mul_ext(input elem_ext_t a, input elem_ext_t b);
        logic signed [2*MUL_OP_W+1:0] p;
        p = $signed(a) * $signed(b);
        return p[2*MUL_OP_W-1:0];
    endfunction

    op_word_t vs1_w;
    op_word_t vs2_w;
    logic     sgn1;
    logic     sgn2;
    logic     keep_high;
    op_word_t prod_d;
    op_word_t prod_q;
    logic     last_q;
    logic     valid_q;
    logic     take;

    assign vs1_w = chunk_i.vs1_word;
    assign vs2_w = chunk_i.vs2_word;

    // vs2 is the signed operand of vmulhsu, vs1 stays unsigned there
    assign sgn2      = (chunk_i.op == MUL_VMULH) | (chunk_i.op == MUL_VMULHSU);
    assign sgn1      = chunk_i.op == MUL_VMULH;
    assign keep_high = chunk_i.op != MUL_VMUL;

    always_comb begin
        prod_dword_t p;
        p      = '0;
        prod_d = '0;
        case (chunk_i.sew)
            SEW_8: begin
                for (int i = 0; i < MUL_OP_W / 8; i++) begin
                    p = mul_ext({{(MUL_OP_W - 7){sgn2 & vs2_w[8*i+7]}}, vs2_w[8*i +: 8]},
                                {{(MUL_OP_W - 7){sgn1 & vs1_w[8*i+7]}}, vs1_w[8*i +: 8]});
                    prod_d[8*i +: 8] = keep_high ? p[15:8] : p[7:0];
                end
            end
            SEW_16: begin
                for (int i = 0; i < MUL_OP_W / 16; i++) begin
                    p = mul_ext({{(MUL_OP_W - 15){sgn2 & vs2_w[16*i+15]}}, vs2_w[16*i +: 16]},
                                {{(MUL_OP_W - 15){sgn1 & vs1_w[16*i+15]}}, vs1_w[16*i +: 16]});
                    prod_d[16*i +: 16] = keep_high ? p[31:16] : p[15:0];
                end
            end
            SEW_32: begin
                p = mul_ext({sgn2 & vs2_w[MUL_OP_W-1], vs2_w}, {sgn1 & vs1_w[MUL_OP_W-1], vs1_w});
                prod_d = keep_high ? p[2*MUL_OP_W-1:MUL_OP_W] : p[MUL_OP_W-1:0];
            end
            default: ;
        endcase
    end

    ////////////////////////////////////////
    // output register

    // accept while empty or while the held product leaves
    assign chunk_i.ready = ~valid_q | prod_o.ready;
    assign take          = chunk_i.valid & chunk_i.ready;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            valid_q <= 1'b0;
        end else if (take) begin
            valid_q <= 1'b1;
        end else if (prod_o.ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            prod_q <= prod_d;
            last_q <= chunk_i.last;
        end
    end

    assign prod_o.valid     = valid_q;
    assign prod_o.prod_word = prod_q;
    assign prod_o.last      = last_q;

endmodule

//--- verilog/vmul_op_pkg.sv
/* vector multiply unit encodings
   element width, multiply operation and sequencer state */
package vmul_op_pkg;

    // element width, applies to the whole vector
    typedef enum logic [1:0] {
        SEW_8  = 2'b00,
        SEW_16 = 2'b01,
        SEW_32 = 2'b10
    } sew_e;

    // vmul keeps the low half, the others keep the high half
    typedef enum logic [1:0] {
        MUL_VMUL    = 2'b00,
        MUL_VMULH   = 2'b01,
        MUL_VMULHU  = 2'b10,
        MUL_VMULHSU = 2'b11
    } mul_op_e;

    typedef enum logic {
        IDLE,
        ISSUE
    } seq_state_e;

endpackage

//--- verilog/vmul_result_collector.sv
`timescale 1ns/1ns
/* result collector, gathers product chunks into a destination vector
   and holds it until the consumer takes it */
module vmul_result_collector #(
    parameter int unsigned VREG_W = vmul_cfg_pkg::DEF_VREG_W
) (
    input  logic              clk_i,
    input  logic              async_rst_ni,
    vmul_prod_if.dst          prod_i,
    output logic              res_valid_o,
    output logic [VREG_W-1:0] res_vd_o,
    input  logic              res_ready_i
);
    import vmul_cfg_pkg::*;

    localparam int unsigned N_CHUNKS = VREG_W / MUL_OP_W;

    if ((VREG_W % MUL_OP_W) != 0 || N_CHUNKS < 2) begin : g_bad_vreg_w
        $fatal(1, "VREG_W must be a multiple of %0d and at least %0d", MUL_OP_W, 2 * MUL_OP_W);
    end

    logic [VREG_W-1:0] vd_q;
    logic              full_q;
    logic              take;

    // no new chunks while a finished vector waits
    assign prod_i.ready = ~full_q;
    assign take         = prod_i.valid & prod_i.ready;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            full_q <= 1'b0;
        end else if (take && prod_i.last) begin
            full_q <= 1'b1;
        end else if (full_q && res_ready_i) begin
            full_q <= 1'b0;
        end
    end

    // new chunks enter at the top, first chunk ends in the lowest bits
    always_ff @(posedge clk_i) begin
        if (take) begin
            vd_q <= {prod_i.prod_word, vd_q[VREG_W-1:MUL_OP_W]};
        end
    end

    assign res_valid_o = full_q;
    assign res_vd_o    = vd_q;

endmodule

//--- verilog/vmul_sequencer.sv
`timescale 1ns/1ns
/* vector multiply chunk sequencer
   accepts an operation and issues its source vectors as 32-bit operand chunks */
module vmul_sequencer #(
    parameter int unsigned VREG_W = vmul_cfg_pkg::DEF_VREG_W
) (
    input  logic                 clk_i,
    input  logic                 async_rst_ni,
    input  logic                 op_rdy_i,
    input  logic [VREG_W-1:0]    vs1_i,
    input  logic [VREG_W-1:0]    vs2_i,
    input  vmul_op_pkg::sew_e    sew_i,
    input  vmul_op_pkg::mul_op_e op_i,
    output logic                 op_ack_o,
    vmul_chunk_if.src            chunk_o
);
    import vmul_cfg_pkg::*;
    import vmul_op_pkg::*;

    localparam int unsigned N_CHUNKS = VREG_W / MUL_OP_W;
    localparam int unsigned CNT_W    = $clog2(N_CHUNKS);

    if ((VREG_W % MUL_OP_W) != 0 || N_CHUNKS < 2) begin : g_bad_vreg_w
        $fatal(1, "VREG_W must be a multiple of %0d and at least %0d", MUL_OP_W, 2 * MUL_OP_W);
    end

    seq_state_e        state_q;
    logic [CNT_W-1:0]  cnt_q;
    logic [VREG_W-1:0] vs1_sh_q;
    logic [VREG_W-1:0] vs2_sh_q;
    sew_e              sew_q;
    mul_op_e           op_q;
    logic              xfer;
    logic              last_chunk;

    // a new operation is only taken once the previous one is fully issued
    assign op_ack_o   = (state_q == IDLE) & op_rdy_i;
    assign xfer       = chunk_o.valid & chunk_o.ready;
    assign last_chunk = cnt_q == CNT_W'(N_CHUNKS - 1);

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else if (op_ack_o) begin
            state_q <= ISSUE;
            cnt_q   <= '0;
        end else if (xfer) begin
            cnt_q <= cnt_q + 1'b1;
            if (last_chunk) begin
                state_q <= IDLE;
            end
        end
    end

    // operand shift registers, lowest chunk is always the current one
    always_ff @(posedge clk_i) begin
        if (op_ack_o) begin
            vs1_sh_q <= vs1_i;
            vs2_sh_q <= vs2_i;
            sew_q    <= sew_i;
            op_q     <= op_i;
        end else if (xfer) begin
            vs1_sh_q <= vs1_sh_q >> MUL_OP_W;
            vs2_sh_q <= vs2_sh_q >> MUL_OP_W;
        end
    end

    assign chunk_o.valid    = state_q == ISSUE;
    assign chunk_o.vs1_word = vs1_sh_q[MUL_OP_W-1:0];
    assign chunk_o.vs2_word = vs2_sh_q[MUL_OP_W-1:0];
    assign chunk_o.sew      = sew_q;
    assign chunk_o.op       = op_q;
    assign chunk_o.last     = last_chunk;

endmodule

//--- verilog/vmul_top.sv
`timescale 1ns/1ns
/* vector integer multiply unit top level
   sequencer, chunk FIFO, multiply lane and result collector in a row */
module vmul_top #(
    parameter int unsigned VREG_W     = vmul_cfg_pkg::DEF_VREG_W,
    parameter int unsigned FIFO_DEPTH = vmul_cfg_pkg::DEF_FIFO_DEPTH
) (
    input  logic                 clk_i,
    input  logic                 async_rst_ni,
    input  logic                 op_rdy_i,
    output logic                 op_ack_o,
    input  logic [VREG_W-1:0]    vs1_i,
    input  logic [VREG_W-1:0]    vs2_i,
    input  vmul_op_pkg::sew_e    sew_i,
    input  vmul_op_pkg::mul_op_e op_i,
    output logic                 res_valid_o,
    output logic [VREG_W-1:0]    res_vd_o,
    input  logic                 res_ready_i
);

    vmul_chunk_if seq_chunk ();
    vmul_chunk_if fifo_chunk ();
    vmul_prod_if  lane_prod ();

    vmul_sequencer #(
        .VREG_W       ( VREG_W       )
    ) u_sequencer (
        .clk_i        ( clk_i        ),
        .async_rst_ni ( async_rst_ni ),
        .op_rdy_i     ( op_rdy_i     ),
        .vs1_i        ( vs1_i        ),
        .vs2_i        ( vs2_i        ),
        .sew_i        ( sew_i        ),
        .op_i         ( op_i         ),
        .op_ack_o     ( op_ack_o     ),
        .chunk_o      ( seq_chunk    )
    );

    vmul_chunk_fifo #(
        .FIFO_DEPTH   ( FIFO_DEPTH   )
    ) u_fifo (
        .clk_i        ( clk_i        ),
        .async_rst_ni ( async_rst_ni ),
        .wr           ( seq_chunk    ),
        .rd           ( fifo_chunk   )
    );

    vmul_lane u_lane (
        .clk_i        ( clk_i        ),
        .async_rst_ni ( async_rst_ni ),
        .chunk_i      ( fifo_chunk   ),
        .prod_o       ( lane_prod    )
    );

    vmul_result_collector #(
        .VREG_W       ( VREG_W       )
    ) u_collector (
        .clk_i        ( clk_i        ),
        .async_rst_ni ( async_rst_ni ),
        .prod_i       ( lane_prod    ),
        .res_valid_o  ( res_valid_o  ),
        .res_vd_o     ( res_vd_o     ),
        .res_ready_i  ( res_ready_i  )
    );

endmodule
